// ==== sim.f ====
periph_pkg.sv
input_debounce.sv
gpio_bank.sv
periph_bus_decode.sv
periph_top.sv
periph_top_sva.sv
tb_periph_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_periph_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_periph_top.sv ====
// testbench for periph_top that assumes a short DEBOUNCE_CYCLES and one access at a time
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top import periph_pkg::*; ();

   logic              clk = 1'b0;
   logic              i_rst_n;
   logic              i_wb_cyc;
   logic              i_wb_stb;
   logic              i_wb_we;
   logic [BUS_AW-1:0] i_wb_adr;
   logic [BUS_DW-1:0] i_wb_dat;
   logic [BUS_DW-1:0] o_wb_rdt;
   logic              o_wb_ack;
   sw_t               i_switch;
   btn_t              i_button;
   sw_t               o_led;
   sw_t               o_led_oe;
   logic              o_irq_sw;
   logic              o_irq_btn;

   // bank model with index 0 for switch/led and 1 for buttons
   logic [31:0] m_in   [2] = '{32'h0, 32'h0};
   logic [31:0] m_out  [2] = '{32'h0, 32'h0};
   logic [31:0] m_oe   [2] = '{32'h0, 32'h0};
   logic [31:0] m_mask [2] = '{32'h0, 32'h0};
   logic [31:0] m_stat [2] = '{32'h0, 32'h0};
   int          errors = 0;
   int          checks = 0;
   logic [31:0] rng    = 32'h5505c0f8;
   // pending read expectations
   logic [31:0] exp_q  [$];
   string       name_q [$];
   // unmapped space and unused indices
   logic [BUS_AW-1:0] zero_adr [5] = '{8'h40, 8'h84, 8'hFC, 8'h14, 8'h3C};

   periph_top i_dut (.*);

   always #4 clk = ~clk;

   // ******************************
   // reference model
   // ******************************

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] width_mask(input int bank);
      return (bank == 0) ? (32'h1 << SW_W) - 32'h1 : (32'h1 << BTN_W) - 32'h1;
   endfunction

   // byte address of a register with the bank on bit 5
   function automatic logic [BUS_AW-1:0] reg_addr(input int bank, input reg_idx_t idx);
      return BUS_AW'(bank << BANK_SEL_BIT) | BUS_AW'({idx, 2'b00});
   endfunction

   function automatic logic [31:0] expected_read(input int bank, input reg_idx_t idx);
      logic [31:0] r;
      case (idx)
         REG_IN:   r = m_in[bank];
         REG_OUT:  r = m_out[bank];
         REG_OE:   r = m_oe[bank];
         REG_MASK: r = m_mask[bank];
         REG_STAT: r = m_stat[bank];
         default:  r = 32'h0;
      endcase
      return r & width_mask(bank);
   endfunction

   task automatic model_write(input int bank, input reg_idx_t idx, input logic [31:0] d);
      logic [31:0] v;
      v = d & width_mask(bank);
      case (idx)
         REG_OUT:  m_out[bank] = v;
         REG_OE:   m_oe[bank] = v;
         REG_MASK: m_mask[bank] = v;
         // write one to clear
         REG_STAT: m_stat[bank] = m_stat[bank] & ~v;
         default:  ;
      endcase
   endtask

   // ******************************
   // bus access and checks
   // ******************************

   // one request and then stb low for a cycle
   task automatic bus_access(input logic we, input logic [BUS_AW-1:0] adr,
                             input logic [31:0] wd, output logic [31:0] rd);
      int n;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = adr;
      i_wb_dat = wd;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (!o_wb_ack && n < 20);
      rd = o_wb_rdt;
      if (!o_wb_ack) begin
         $display("bus access to address %h got no ack within 20 cycles", adr);
         errors++;
         exp_q.delete();
         name_q.delete();
      end else if (n != 1) begin
         $display("ack for address %h came %0d cycles after the request, not 1", adr, n);
         errors++;
      end
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic write_reg(input int bank, input reg_idx_t idx, input logic [31:0] d);
      logic [31:0] rd;
      bus_access(1'b1, reg_addr(bank, idx), d, rd);
      model_write(bank, idx, d);
   endtask

   task automatic check_reg(input int bank, input reg_idx_t idx);
      logic [31:0] rd;
      exp_q.push_back(expected_read(bank, idx));
      name_q.push_back($sformatf("bank %0d reg %0d", bank, idx));
      bus_access(1'b0, reg_addr(bank, idx), 32'h0, rd);
   endtask

   task automatic check_sig(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_irqs();
      check_sig("o_irq_sw", 32'(o_irq_sw), 32'(|(m_stat[0] & m_mask[0])));
      check_sig("o_irq_btn", 32'(o_irq_btn), 32'(|(m_stat[1] & m_mask[1])));
   endtask

   // drive a new pad level and poll REG_IN until it passes the debouncer
   task automatic settle_input(input int bank, input logic [31:0] v);
      logic [31:0] rd;
      int n;
      if (bank == 0) begin
         i_switch = sw_t'(v);
      end else begin
         i_button = btn_t'(v);
      end
      n = 0;
      do begin
         bus_access(1'b0, reg_addr(bank, REG_IN), 32'h0, rd);
         n++;
      end while (rd !== (v & width_mask(bank)) && n < 40);
      if (rd !== (v & width_mask(bank))) begin
         $display("input of bank %0d never settled to %h in REG_IN", bank, v);
         errors++;
      end
      m_stat[bank] = m_stat[bank] | ((m_in[bank] ^ v) & width_mask(bank));
      m_in[bank]   = v & width_mask(bank);
   endtask

   // read data checked mid-cycle while ack is high
   always @(negedge clk) begin
      if (o_wb_ack && exp_q.size() != 0) begin
         checks++;
         if (o_wb_rdt !== exp_q[0]) begin
            $display("error o_wb_rdt (%s): got %h, expected %h", name_q[0], o_wb_rdt, exp_q[0]);
            errors++;
         end
         void'(exp_q.pop_front());
         void'(name_q.pop_front());
      end
   end

   // ******************************
   // stimulus
   // ******************************

   initial begin
      logic [31:0] rd;
      logic [31:0] old;
      int          b;
      int          k;
      i_rst_n  = 1'b0;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      i_wb_adr = '0;
      i_wb_dat = '0;
      i_switch = '0;
      i_button = '0;
      repeat (8) @(posedge clk);
      #1;
      i_rst_n = 1'b1;

      // reset state
      check_sig("o_wb_ack", 32'(o_wb_ack), 32'h0);
      check_sig("o_led", 32'(o_led), 32'h0);
      check_sig("o_led_oe", 32'(o_led_oe), 32'h0);
      check_irqs();
      for (b = 0; b < 2; b++) begin
         check_reg(b, REG_STAT);
         check_reg(b, REG_MASK);
      end

      // random register traffic truncated to bank width
      for (k = 0; k < 6; k++) begin
         for (b = 0; b < 2; b++) begin
            rng = xorshift32(rng);
            write_reg(b, REG_OUT, rng);
            rng = xorshift32(rng);
            write_reg(b, REG_OE, rng);
            rng = xorshift32(rng);
            write_reg(b, REG_MASK, rng);
            check_reg(b, REG_OUT);
            check_reg(b, REG_OE);
            check_reg(b, REG_MASK);
         end
         check_sig("o_led", 32'(o_led), m_out[0]);
         check_sig("o_led_oe", 32'(o_led_oe), m_oe[0]);
      end

      // steady level passes but a half length pulse does not
      rng = xorshift32(rng);
      settle_input(0, rng);
      check_reg(0, REG_IN);
      old = m_in[0];
      i_switch = ~i_switch;
      repeat (DEBOUNCE_CYCLES / 2) @(posedge clk);
      #1;
      i_switch = sw_t'(old);
      repeat (DEBOUNCE_CYCLES * 3) @(posedge clk);
      #1;
      check_reg(0, REG_IN);
      check_reg(0, REG_STAT);

      // switch irq with mask set and then with mask clear
      write_reg(0, REG_STAT, 32'hFFFF_FFFF);
      write_reg(0, REG_MASK, 32'hFFFF);
      rng = xorshift32(rng);
      settle_input(0, m_in[0] ^ (rng | 32'h1));
      check_reg(0, REG_STAT);
      check_sig("o_irq_sw", 32'(o_irq_sw), 32'h1);
      write_reg(0, REG_STAT, m_stat[0]);
      check_reg(0, REG_STAT);
      check_irqs();
      write_reg(0, REG_MASK, 32'h0);
      settle_input(0, ~m_in[0]);
      check_reg(0, REG_STAT);
      check_sig("o_irq_sw", 32'(o_irq_sw), 32'h0);
      write_reg(0, REG_STAT, m_stat[0]);

      // button bank irq while the switch bank stays put
      write_reg(1, REG_STAT, 32'hFFFF_FFFF);
      write_reg(1, REG_MASK, 32'h1F);
      rng = xorshift32(rng);
      settle_input(1, m_in[1] ^ (rng | 32'h1));
      check_reg(1, REG_STAT);
      check_reg(0, REG_STAT);
      check_sig("o_irq_btn", 32'(o_irq_btn), 32'h1);
      check_irqs();
      write_reg(1, REG_STAT, m_stat[1]);
      check_reg(1, REG_STAT);
      check_irqs();

      // unmapped write is dropped and holes read zero
      bus_access(1'b1, 8'h44, 32'hA5A5_A5A5, rd);
      check_reg(0, REG_OUT);
      foreach (zero_adr[i]) begin
         exp_q.push_back(32'h0);
         name_q.push_back($sformatf("address %h", zero_adr[i]));
         bus_access(1'b0, zero_adr[i], 32'h0, rd);
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== periph_top_sva.sv ====
// bound into periph_top and reads both banks' mask registers by hierarchical name
`timescale 1ns/1ps
`default_nettype none

module periph_top_sva import periph_pkg::*; (
   input wire logic clk,
   input wire logic i_rst_n,
   input wire logic i_wb_cyc,
   input wire logic i_wb_stb,
   input wire logic o_wb_ack,
   input wire logic o_irq_sw,
   input wire logic o_irq_btn,
   input wire sw_t  i_sw_mask,
   input wire btn_t i_btn_mask
);

   // ack is a one cycle pulse
   ack_single: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wb_ack |=> !o_wb_ack)
      else $error("o_wb_ack high for two cycles in a row");

   // no ack without a request the cycle before
   ack_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
      else $error("o_wb_ack rose with no request in the previous cycle");

   // masked off bank never interrupts
   sw_irq_masked: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_sw_mask == '0) |-> !o_irq_sw)
      else $error("o_irq_sw high while the switch bank mask is zero");

   btn_irq_masked: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_btn_mask == '0) |-> !o_irq_btn)
      else $error("o_irq_btn high while the button bank mask is zero");

endmodule

bind periph_top periph_top_sva u_sva (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_wb_cyc   (i_wb_cyc),
   .i_wb_stb   (i_wb_stb),
   .o_wb_ack   (o_wb_ack),
   .o_irq_sw   (o_irq_sw),
   .o_irq_btn  (o_irq_btn),
   .i_sw_mask  (u_sw_bank.mask_q),
   .i_btn_mask (u_btn_bank.mask_q)
);

`default_nettype wire

// ==== periph_top.sv ====
// board inputs are asynchronous and the led output enable is a plain output with no pad cell
`timescale 1ns/1ps
`default_nettype none

module periph_top import periph_pkg::*; (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   // register bus
   input  wire logic              i_wb_cyc,
   input  wire logic              i_wb_stb,
   input  wire logic              i_wb_we,
   input  wire logic [BUS_AW-1:0] i_wb_adr,
   input  wire logic [BUS_DW-1:0] i_wb_dat,
   output logic [BUS_DW-1:0]      o_wb_rdt,
   output logic                   o_wb_ack,
   // board
   input  wire sw_t               i_switch,
   input  wire btn_t              i_button,
   output sw_t                    o_led,
   output sw_t                    o_led_oe,
   output logic                   o_irq_sw,
   output logic                   o_irq_btn
);

   // debounced levels
   sw_t               sw_db;
   btn_t              btn_db;

   // decoder to banks
   logic              sw_wr;
   logic              btn_wr;
   reg_idx_t          reg_idx;
   logic [BUS_DW-1:0] wdat;
   logic [BUS_DW-1:0] sw_rdat;
   logic [BUS_DW-1:0] btn_rdat;

   // ******************************
   // debouncers
   // ******************************

   input_debounce #(.data_t(sw_t)) u_sw_db (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_raw   (i_switch),
      .o_db    (sw_db)
   );

   input_debounce #(.data_t(btn_t)) u_btn_db (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_raw   (i_button),
      .o_db    (btn_db)
   );

   // ******************************
   // gpio banks
   // ******************************

   // switches in, leds out
   gpio_bank #(.data_t(sw_t)) u_sw_bank (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wr      (sw_wr),
      .i_reg_idx (reg_idx),
      .i_wdat    (wdat),
      .o_rdat    (sw_rdat),
      .i_pad_in  (sw_db),
      .o_pad_out (o_led),
      .o_pad_oe  (o_led_oe),
      .o_irq     (o_irq_sw)
   );

   // buttons are input only, out and oe stay open
   gpio_bank #(.data_t(btn_t)) u_btn_bank (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wr      (btn_wr),
      .i_reg_idx (reg_idx),
      .i_wdat    (wdat),
      .o_rdat    (btn_rdat),
      .i_pad_in  (btn_db),
      .o_pad_out (),
      .o_pad_oe  (),
      .o_irq     (o_irq_btn)
   );

   periph_bus_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_wb_we    (i_wb_we),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack),
      .o_sw_wr    (sw_wr),
      .o_btn_wr   (btn_wr),
      .o_reg_idx  (reg_idx),
      .o_wdat     (wdat),
      .i_sw_rdat  (sw_rdat),
      .i_btn_rdat (btn_rdat)
   );

endmodule

`default_nettype wire

// ==== periph_bus_decode.sv ====
// one access at a time and the master must drop stb for a cycle after each ack
`timescale 1ns/1ps
`default_nettype none

module periph_bus_decode import periph_pkg::*; (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   // wishbone slave side
   input  wire logic              i_wb_cyc,
   input  wire logic              i_wb_stb,
   input  wire logic              i_wb_we,
   input  wire logic [BUS_AW-1:0] i_wb_adr,
   input  wire logic [BUS_DW-1:0] i_wb_dat,
   output logic [BUS_DW-1:0]      o_wb_rdt,
   output logic                   o_wb_ack,
   // bank side
   output logic                   o_sw_wr,
   output logic                   o_btn_wr,
   output reg_idx_t               o_reg_idx,
   output logic [BUS_DW-1:0]      o_wdat,
   input  wire logic [BUS_DW-1:0] i_sw_rdat,
   input  wire logic [BUS_DW-1:0] i_btn_rdat
);

   logic new_req;
   logic mapped;
   logic sel_btn;

   // ******************************
   // address decode
   // ******************************

   // not yet acked
   assign new_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

   // bits above the bank select must be clear
   assign mapped  = ~|i_wb_adr[BUS_AW-1:BANK_SEL_BIT+1];
   assign sel_btn = i_wb_adr[BANK_SEL_BIT];

   // word index within the bank
   assign o_reg_idx = i_wb_adr[BANK_SEL_BIT-1 -: REG_IDX_W];
   assign o_wdat    = i_wb_dat;

   // write strobes for the selected bank only
   assign o_sw_wr  = new_req && i_wb_we && mapped && !sel_btn;
   assign o_btn_wr = new_req && i_wb_we && mapped && sel_btn;

   // ******************************
   // ack and read data
   // ******************************

   // single cycle ack pulse
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_ack <= 1'b0;
      end else begin
         o_wb_ack <= new_req;
      end
   end

   // captured with the ack
   always_ff @(posedge clk) begin
      if (new_req) begin
         if (!mapped) begin
            o_wb_rdt <= '0;
         end else if (sel_btn) begin
            o_wb_rdt <= i_btn_rdat;
         end else begin
            o_wb_rdt <= i_sw_rdat;
         end
      end
   end

endmodule

`default_nettype wire

// ==== gpio_bank.sv ====
// payload must be at most 32 bits wide and i_pad_in is expected to be synchronous already
`timescale 1ns/1ps
`default_nettype none

module gpio_bank import periph_pkg::*; #(
   parameter type data_t = sw_t
) (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   input  wire logic              i_wr,
   input  wire reg_idx_t          i_reg_idx,
   input  wire logic [BUS_DW-1:0] i_wdat,
   output logic [BUS_DW-1:0]      o_rdat,
   input  wire data_t             i_pad_in,
   output data_t                  o_pad_out,
   output data_t                  o_pad_oe,
   output logic                   o_irq
);

   localparam int W = $bits(data_t);

   // ******************************
   // registers
   // ******************************

   data_t out_q;
   data_t oe_q;
   data_t mask_q;
   data_t stat_q;
   // previous input for edge detect
   data_t prev_q;

   data_t change;
   data_t clr;
   data_t wval;
   logic  wr_out;
   logic  wr_oe;
   logic  wr_mask;
   logic  wr_stat;

   // per register write enables
   assign wr_out  = i_wr && (i_reg_idx == REG_OUT);
   assign wr_oe   = i_wr && (i_reg_idx == REG_OE);
   assign wr_mask = i_wr && (i_reg_idx == REG_MASK);
   assign wr_stat = i_wr && (i_reg_idx == REG_STAT);

   // upper bus bits dropped
   assign wval   = i_wdat[W-1:0];

   // either direction counts
   assign change = i_pad_in ^ prev_q;
   assign clr    = wr_stat ? wval : '0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q  <= '0;
         oe_q   <= '0;
         mask_q <= '0;
         stat_q <= '0;
         prev_q <= '0;
      end else begin
         prev_q <= i_pad_in;
         if (wr_out) begin
            out_q <= wval;
         end
         if (wr_oe) begin
            oe_q <= wval;
         end
         if (wr_mask) begin
            mask_q <= wval;
         end
         // a new change wins over a clear in the same cycle
         stat_q <= (stat_q & ~clr) | change;
      end
   end

   // ******************************
   // read mux and outputs
   // ******************************

   always_comb begin
      o_rdat = '0;
      case (i_reg_idx)
         REG_IN:   o_rdat = BUS_DW'(i_pad_in);
         REG_OUT:  o_rdat = BUS_DW'(out_q);
         REG_OE:   o_rdat = BUS_DW'(oe_q);
         REG_MASK: o_rdat = BUS_DW'(mask_q);
         REG_STAT: o_rdat = BUS_DW'(stat_q);
         // unused indices
         default:  o_rdat = '0;
      endcase
   end

   assign o_pad_out = out_q;
   assign o_pad_oe  = oe_q;

   // level irq, any masked status bit
   assign o_irq = |(stat_q & mask_q);

endmodule

`default_nettype wire

// ==== input_debounce.sv ====
// i_raw is taken as fully asynchronous and every bit shares one counter, so any bit moving restarts it
`timescale 1ns/1ps
`default_nettype none

module input_debounce import periph_pkg::*; #(
   parameter type data_t = sw_t
) (
   input  wire logic  clk,
   input  wire logic  i_rst_n,
   input  wire data_t i_raw,
   output data_t      o_db
);

   // two flop synchronizer
   data_t               sync1_q;
   data_t               sync2_q;
   // last synchronized sample
   data_t               sample_q;
   logic [DB_CNT_W-1:0] cnt_q;
   logic                stable;
   logic                differs;

   // input held since last cycle
   assign stable  = (sync2_q == sample_q);
   // held value not yet passed on
   assign differs = (sample_q != o_db);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sync1_q  <= '0;
         sync2_q  <= '0;
         sample_q <= '0;
         cnt_q    <= '0;
         o_db     <= '0;
      end else begin
         sync1_q  <= i_raw;
         sync2_q  <= sync1_q;
         sample_q <= sync2_q;
         // glitch or nothing new, start over
         if (!stable || !differs) begin
            cnt_q <= '0;
         end else if (cnt_q == DB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            // held long enough
            cnt_q <= '0;
            o_db  <= sample_q;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== periph_pkg.sv ====
// word bus with byte addresses below 0x100 and a debounce length that only suits simulation
`default_nettype none

package periph_pkg;

   // ******************************
   // bus geometry
   // ******************************

   // 32-bit data, byte addressed
   localparam int BUS_DW       = 32;
   localparam int BUS_AW       = 8;

   // bit 5 picks the button bank over the switch bank
   // anything above bit 5 set means unmapped
   localparam int BANK_SEL_BIT = 5;

   // register index sits in address bits 4..2
   localparam int REG_IDX_W    = 3;

   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // ******************************
   // register map inside a bank
   // ******************************

   // debounced input, read only
   localparam reg_idx_t REG_IN   = reg_idx_t'(0);
   localparam reg_idx_t REG_OUT  = reg_idx_t'(1);
   localparam reg_idx_t REG_OE   = reg_idx_t'(2);
   localparam reg_idx_t REG_MASK = reg_idx_t'(3);
   // write one to clear
   localparam reg_idx_t REG_STAT = reg_idx_t'(4);
   // indices 5..7 read zero, writes dropped

   // ******************************
   // board inputs
   // ******************************

   // slide switches and leds share one width
   localparam int SW_W  = 16;
   localparam int BTN_W = 5;

   // stable cycles before the debounced value follows
   localparam int DEBOUNCE_CYCLES = 16;
   localparam int DB_CNT_W        = $clog2(DEBOUNCE_CYCLES + 1);

   typedef logic [SW_W-1:0]  sw_t;
   typedef logic [BTN_W-1:0] btn_t;

endpackage

`default_nettype wire
